/* pipe_trace_unit.f */
source/pipe_pkg.sv
source/trace_pkg.sv
source/trace_tag_pipe.sv
source/fetch_record_store.sv
source/retire_report.sv
source/pipe_trace_unit.sv
bench/pipe_trace_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the pipeline trace unit testbench with Verilator

top=pipe_trace_unit_tb
log=sim.log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

verilator --binary --timing --assert -f pipe_trace_unit.f --top-module "$top" -o "$top"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
    echo "simulation reported failures, see $log"
    exit 1
fi

echo "simulation finished without failures"
exit 0

/* bench/pipe_trace_unit_tb.sv */
/*
 * testbench for the pipeline trace unit
 *   clock, reset and LCG driven stimulus in place of the core
 *   behavioral model of the stage rules with an expected record queue
 *   directed and random tests, watchdog, per-test lines and summary
 */

`timescale 1ns/1ps

module pipe_trace_unit_tb;
    import pipe_pkg::*;
    import trace_pkg::*;

    localparam int clk_period    = 40;
    localparam int random_cycles = 2000;
    // reset, directed tests and drain together
    localparam int fixed_cycles  = 120;
    localparam int watchdog_ns   = (random_cycles + fixed_cycles + 50) * clk_period;

    // one expected retirement record
    typedef struct packed {
        seq_t       seq;
        instr_t     instr;
        cycle_t     latency;
        stall_cnt_t stalls;
    } record_t;

    logic        clk;
    logic        rst;
    logic        fetch_fire;
    instr_t      fetch_instr;
    logic        stall;
    logic        flush;
    logic        retire_valid;
    seq_t        retire_seq;
    instr_t      retire_instr;
    cycle_t      retire_latency;
    stall_cnt_t  retire_stalls;
    squash_cnt_t squash_count;

    // model slots, indexed by stage_e
    logic        m_valid   [pipe_depth];
    seq_t        m_seq     [pipe_depth];
    instr_t      m_instr   [pipe_depth];
    cycle_t      m_fetched [pipe_depth];
    stall_cnt_t  m_stalls  [pipe_depth];
    cycle_t      m_cycle;
    seq_t        m_next_seq;
    squash_cnt_t m_squash;
    record_t     exp_q [$];

    logic [31:0] rng_state;
    string       test_name;
    // directed test with no stalls expects the minimum latency
    logic        exact_latency;
    int          err_count;
    int          test_err_start;
    int          tests_run;
    int          tests_failed;
    int          records_checked;
    int          fetched_total;
    int          retired_total;

    pipe_trace_unit dut_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_fire     (fetch_fire),
        .fetch_instr    (fetch_instr),
        .stall          (stall),
        .flush          (flush),
        .retire_valid   (retire_valid),
        .retire_seq     (retire_seq),
        .retire_instr   (retire_instr),
        .retire_latency (retire_latency),
        .retire_stalls  (retire_stalls),
        .squash_count   (squash_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = lcg_next(rng_state);
        value = rng_state;
    endtask

    // inputs change just after the rising edge
    task automatic drive_cycle(input logic ff, input instr_t instr, input logic st,
                               input logic fl);
        @(posedge clk);
        fetch_fire  <= ff;
        fetch_instr <= instr;
        stall       <= st;
        flush       <= fl;
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    task automatic model_reset();
        for (int i = 0; i < pipe_depth; i++) begin
            m_valid[i] = 1'b0;
        end
        m_cycle       = '0;
        m_next_seq    = '0;
        m_squash      = '0;
        fetched_total = 0;
        retired_total = 0;
        exp_q.delete();
    endtask

    task automatic move_slot(input stage_e dst, input stage_e src);
        m_valid[dst]   = m_valid[src];
        m_seq[dst]     = m_seq[src];
        m_instr[dst]   = m_instr[src];
        m_fetched[dst] = m_fetched[src];
        m_stalls[dst]  = m_stalls[src];
    endtask

    // one clock edge of the stage rules, back to front
    task automatic model_step();
        cycle_t  now;
        record_t rec;
        now = m_cycle;
        move_slot(stage_writeback, stage_memory);
        move_slot(stage_memory, stage_execute);
        if (flush) begin
            // flush wins, front end tags are lost
            if (m_valid[stage_fetch]) begin
                m_squash = m_squash + squash_cnt_t'(1);
            end
            if (m_valid[stage_decode]) begin
                m_squash = m_squash + squash_cnt_t'(1);
            end
            m_valid[stage_execute] = 1'b0;
            m_valid[stage_decode]  = 1'b0;
            m_valid[stage_fetch]   = 1'b0;
        end else if (stall) begin
            m_valid[stage_execute] = 1'b0;
            if (m_valid[stage_decode] && m_stalls[stage_decode] != '1) begin
                m_stalls[stage_decode] = m_stalls[stage_decode] + stall_cnt_t'(1);
            end
        end else begin
            move_slot(stage_execute, stage_decode);
            move_slot(stage_decode, stage_fetch);
            m_stalls[stage_decode] = '0;
            m_valid[stage_fetch]   = fetch_fire;
            m_seq[stage_fetch]     = m_next_seq;
            m_instr[stage_fetch]   = fetch_instr;
            m_fetched[stage_fetch] = now;
        end
        if (fetch_fire) begin
            m_next_seq = m_next_seq + seq_t'(1);
            fetched_total++;
        end
        // entry into write-back fixes the record
        if (m_valid[stage_writeback]) begin
            rec.seq     = m_seq[stage_writeback];
            rec.instr   = m_instr[stage_writeback];
            rec.latency = now - m_fetched[stage_writeback];
            rec.stalls  = m_stalls[stage_writeback];
            exp_q.push_back(rec);
        end
        m_cycle = now + cycle_t'(1);
    endtask

    task automatic compare_retire();
        record_t exp;
        if (retire_valid) begin
            retired_total++;
            if (exp_q.size() == 0) begin
                $display("Error in %s: seq %0d retired with no instruction in flight",
                         test_name, retire_seq);
                err_count++;
            end else begin
                exp = exp_q.pop_front();
                records_checked++;
                if (retire_seq !== exp.seq) begin
                    $display("Fail %s retire_seq: expected %0d actual %0d",
                             test_name, exp.seq, retire_seq);
                    err_count++;
                end
                if (retire_instr !== exp.instr) begin
                    $display("Fail %s retire_instr: expected %h actual %h",
                             test_name, exp.instr, retire_instr);
                    err_count++;
                end
                if (retire_latency !== exp.latency) begin
                    $display("Fail %s retire_latency: expected %0d actual %0d",
                             test_name, exp.latency, retire_latency);
                    err_count++;
                end
                if (retire_stalls !== exp.stalls) begin
                    $display("Fail %s retire_stalls: expected %0d actual %0d",
                             test_name, exp.stalls, retire_stalls);
                    err_count++;
                end
                if (exact_latency && retire_latency !== cycle_t'(pipe_depth - 1)) begin
                    $display("Fail %s minimum latency: expected %0d actual %0d",
                             test_name, pipe_depth - 1, retire_latency);
                    err_count++;
                end
            end
        end
    endtask

    // outputs seen here are the values before this edge
    always @(posedge clk) begin
        if (rst) begin
            model_reset();
        end else begin
            compare_retire();
            model_step();
        end
    end

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = err_count;
    endtask

    task automatic finish_test();
        int errs;
        errs = err_count - test_err_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errs);
        end
    endtask

    task automatic wait_retired(input int target, input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (retired_total < target && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (retired_total < target) begin
            $display("Error in %s: only %0d of %0d records retired within %0d cycles",
                     test_name, retired_total, target, limit);
            err_count++;
        end
    endtask

    task automatic check_squash();
        if (squash_count !== m_squash) begin
            $display("Fail %s squash_count: expected %0d actual %0d",
                     test_name, m_squash, squash_count);
            err_count++;
        end
    endtask

    task automatic test_reset_idle();
        start_test("reset_idle");
        repeat (10) begin
            @(negedge clk);
            if (retire_valid !== 1'b0) begin
                $display("Fail %s retire_valid: expected 0 actual %b", test_name, retire_valid);
                err_count++;
            end
            if (squash_count !== '0) begin
                $display("Fail %s squash_count: expected 0 actual %0d", test_name, squash_count);
                err_count++;
            end
        end
        finish_test();
    endtask

    // back-to-back fetches with no stall retire after exactly 4 cycles
    task automatic test_no_stall_latency();
        int target;
        start_test("no_stall_latency");
        exact_latency = 1'b1;
        target = retired_total + 6;
        for (int i = 0; i < 6; i++) begin
            drive_cycle(1'b1, 32'h0010_0093 + i, 1'b0, 1'b0);
        end
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
        wait_retired(target, 20);
        exact_latency = 1'b0;
        finish_test();
    endtask

    // two tags in fetch and decode, then two flushes in a row
    task automatic test_double_flush();
        squash_cnt_t squash_start;
        int          retired_before;
        start_test("double_flush");
        @(negedge clk);
        squash_start   = m_squash;
        retired_before = retired_total;
        drive_cycle(1'b1, 32'h0000_0063, 1'b0, 1'b0);
        drive_cycle(1'b1, 32'h0000_006f, 1'b0, 1'b0);
        drive_cycle(1'b0, '0, 1'b0, 1'b1);
        drive_cycle(1'b0, '0, 1'b0, 1'b1);
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
        // long enough for both to reach write-back had they survived
        repeat (8) @(negedge clk);
        if (squash_count !== squash_start + squash_cnt_t'(2)) begin
            $display("Fail %s squash_count: expected %0d actual %0d",
                     test_name, squash_start + squash_cnt_t'(2), squash_count);
            err_count++;
        end
        check_squash();
        if (retired_total != retired_before) begin
            $display("Error in %s: a flushed instruction still retired", test_name);
            err_count++;
        end
        finish_test();
    endtask

    task automatic test_random_traffic();
        logic [31:0] r;
        logic        st;
        logic        fl;
        logic        ff;
        instr_t      word;
        start_test("random_traffic");
        repeat (random_cycles) begin
            draw_random(r);
            st = (r[31:16] % 16'd6) == 16'd0;
            draw_random(r);
            fl = (r[31:16] % 16'd6) == 16'd0;
            draw_random(r);
            // fetch about three cycles in four, never beside stall or flush
            ff = (r[31:30] != 2'b00) && !st && !fl;
            draw_random(word);
            drive_cycle(ff, word, st, fl);
        end
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
        @(negedge clk);
        check_squash();
        finish_test();
    endtask

    // every accepted fetch either retired once or was squashed
    task automatic test_drain();
        start_test("drain");
        repeat (8) @(posedge clk);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("Error in %s: %0d expected records never retired", test_name, exp_q.size());
            err_count++;
        end
        if (retired_total != fetched_total - int'(m_squash)) begin
            $display("Fail %s retired count: expected %0d actual %0d",
                     test_name, fetched_total - int'(m_squash), retired_total);
            err_count++;
        end
        check_squash();
        finish_test();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        rst             = 1'b1;
        fetch_fire      = 1'b0;
        fetch_instr     = '0;
        stall           = 1'b0;
        flush           = 1'b0;
        rng_state       = 32'h8764_bc6e;
        test_name       = "reset";
        exact_latency   = 1'b0;
        err_count       = 0;
        test_err_start  = 0;
        tests_run       = 0;
        tests_failed    = 0;
        records_checked = 0;
        fetched_total   = 0;
        retired_total   = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_reset_idle();
        test_no_stall_latency();
        test_double_flush();
        test_random_traffic();
        test_drain();

        $display("summary: %0d tests run, %0d failed, %0d records checked, %0d errors",
                 tests_run, tests_failed, records_checked, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* source/pipe_trace_unit.sv */
/*
 * pipeline trace unit top level
 *   tag tracker, fetch record store and write-back reporter
 */

`timescale 1ns/1ps

module pipe_trace_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_fire,
    input  pipe_pkg::instr_t       fetch_instr,
    input  logic                   stall,
    input  logic                   flush,
    output logic                   retire_valid,
    output trace_pkg::seq_t        retire_seq,
    output pipe_pkg::instr_t       retire_instr,
    output trace_pkg::cycle_t      retire_latency,
    output trace_pkg::stall_cnt_t  retire_stalls,
    output trace_pkg::squash_cnt_t squash_count
);
    import pipe_pkg::*;
    import trace_pkg::*;

    // tracker to store and reporter
    cycle_t     cycle_count;
    logic       new_valid;
    seq_t       new_seq;
    logic       wb_enter;
    seq_t       wb_seq;
    stall_cnt_t wb_stalls;

    // store read port
    seq_t       rd_seq;
    instr_t     rd_instr;
    cycle_t     rd_fetch_cycle;

    trace_tag_pipe tag_pipe_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_fire   (fetch_fire),
        .stall        (stall),
        .flush        (flush),
        .cycle_count  (cycle_count),
        .new_valid    (new_valid),
        .new_seq      (new_seq),
        .wb_enter     (wb_enter),
        .wb_seq       (wb_seq),
        .wb_stalls    (wb_stalls),
        .squash_count (squash_count)
    );

    fetch_record_store store_i (
        .clk            (clk),
        .rst            (rst),
        .new_valid      (new_valid),
        .new_seq        (new_seq),
        .fetch_instr    (fetch_instr),
        .cycle_count    (cycle_count),
        .rd_seq         (rd_seq),
        .rd_instr       (rd_instr),
        .rd_fetch_cycle (rd_fetch_cycle)
    );

    retire_report report_i (
        .clk            (clk),
        .rst            (rst),
        .wb_enter       (wb_enter),
        .wb_seq         (wb_seq),
        .wb_stalls      (wb_stalls),
        .rd_instr       (rd_instr),
        .rd_fetch_cycle (rd_fetch_cycle),
        .cycle_count    (cycle_count),
        .rd_seq         (rd_seq),
        .retire_valid   (retire_valid),
        .retire_seq     (retire_seq),
        .retire_instr   (retire_instr),
        .retire_latency (retire_latency),
        .retire_stalls  (retire_stalls)
    );

endmodule

/* source/retire_report.sv */
/*
 * write-back reporter
 *   store read address from the write-back tag
 *   registered one-cycle retirement record
 *   latency from fetch stamp to write-back entry cycle
 */

`timescale 1ns/1ps

module retire_report (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_enter,
    input  trace_pkg::seq_t       wb_seq,
    input  trace_pkg::stall_cnt_t wb_stalls,
    input  pipe_pkg::instr_t      rd_instr,
    input  trace_pkg::cycle_t     rd_fetch_cycle,
    input  trace_pkg::cycle_t     cycle_count,
    output trace_pkg::seq_t       rd_seq,
    output logic                  retire_valid,
    output trace_pkg::seq_t       retire_seq,
    output pipe_pkg::instr_t      retire_instr,
    output trace_pkg::cycle_t     retire_latency,
    output trace_pkg::stall_cnt_t retire_stalls
);
    import trace_pkg::*;

    // cycle count at the edge the tag entered write-back
    cycle_t wb_entry_cycle;

    // look up the fetch record of the tag now in write-back
    assign rd_seq = wb_seq;

    // the counter has moved one past the entry edge by now
    assign wb_entry_cycle = cycle_count - cycle_t'(1);

    //////////////////////////////
    // record strobe
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_enter;
        end
    end

    //////////////////////////////
    // record fields
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (wb_enter) begin
            retire_seq     <= wb_seq;
            retire_instr   <= rd_instr;
            // modulo 16 bits, wraps with the counter
            retire_latency <= wb_entry_cycle - rd_fetch_cycle;
            retire_stalls  <= wb_stalls;
        end
    end

    // fetch to write-back takes at least one edge per stage boundary
    min_latency_a: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid |-> retire_latency >= cycle_t'(pipe_depth - 1)
    ) else $error("seq %0d retired after only %0d cycles", retire_seq, retire_latency);

endmodule

/* source/fetch_record_store.sv */
/*
 * per-instruction record store
 *   16-entry array of fetch cycle and instruction word
 *   written on accepted fetch, read combinationally by sequence number
 *   live bits and the overrun check
 */

`timescale 1ns/1ps

module fetch_record_store (
    input  logic              clk,
    input  logic              rst,
    input  logic              new_valid,
    input  trace_pkg::seq_t   new_seq,
    input  pipe_pkg::instr_t  fetch_instr,
    input  trace_pkg::cycle_t cycle_count,
    input  trace_pkg::seq_t   rd_seq,
    output pipe_pkg::instr_t  rd_instr,
    output trace_pkg::cycle_t rd_fetch_cycle
);
    import pipe_pkg::*;
    import trace_pkg::*;

    // record storage
    instr_t instr_mem [store_depth];
    cycle_t stamp_mem [store_depth];
    // full sequence number of the occupant
    seq_t   tag_mem   [store_depth];

    // entry written and not yet reached by the read pointer
    logic [store_depth-1:0] live;
    logic [store_depth-1:0] passed;

    logic [store_aw-1:0] wr_addr;
    logic [store_aw-1:0] rd_addr;

    assign wr_addr = new_seq[store_aw-1:0];
    assign rd_addr = rd_seq[store_aw-1:0];

    // asynchronous read for the reporter
    assign rd_instr       = instr_mem[rd_addr];
    assign rd_fetch_cycle = stamp_mem[rd_addr];

    always_ff @(posedge clk) begin
        if (new_valid) begin
            instr_mem[wr_addr] <= fetch_instr;
            stamp_mem[wr_addr] <= cycle_count;
            tag_mem[wr_addr]   <= new_seq;
        end
    end

    // an entry at or behind the read pointer has retired or was squashed
    // skipped squashed entries are swept when a later tag is read
    always_comb begin
        seq_t age;
        for (int i = 0; i < store_depth; i++) begin
            age       = rd_seq - tag_mem[i];
            passed[i] = !age[$bits(seq_t)-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live <= '0;
        end else begin
            for (int i = 0; i < store_depth; i++) begin
                if (new_valid && wr_addr == store_aw'(i)) begin
                    live[i] <= 1'b1;
                end else if (passed[i]) begin
                    live[i] <= 1'b0;
                end
            end
        end
    end

    // a write over a live entry means the read side fell a full store behind
    no_overrun_a: assert property (
        @(posedge clk) disable iff (rst) new_valid |-> !live[wr_addr]
    ) else $error("record store overrun at seq %0d", new_seq);

endmodule

/* source/trace_tag_pipe.sv */
/*
 * stage tag tracker
 *   free running cycle counter and fetch sequence numbering
 *   one valid/seq/stall-count slot per pipeline stage
 *   core stall and flush rules, squash counter
 *   write-back entry strobe for the reporter
 */

`timescale 1ns/1ps

module trace_tag_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_fire,
    input  logic                   stall,
    input  logic                   flush,
    output trace_pkg::cycle_t      cycle_count,
    output logic                   new_valid,
    output trace_pkg::seq_t        new_seq,
    output logic                   wb_enter,
    output trace_pkg::seq_t        wb_seq,
    output trace_pkg::stall_cnt_t  wb_stalls,
    output trace_pkg::squash_cnt_t squash_count
);
    import pipe_pkg::*;
    import trace_pkg::*;

    // slot state, indexed by stage_e
    logic [pipe_depth-1:0] slot_valid;
    seq_t                  slot_seq [pipe_depth];
    // fetch has no stall count of its own
    stall_cnt_t            slot_stalls [stage_decode:stage_writeback];

    // sequence number handed to the next accepted fetch
    seq_t next_seq;

    // last tag seen in write-back, for the order check
    seq_t last_wb_seq;
    logic wb_seen;
    seq_t wb_seq_gap;

    // every accepted fetch opens a record in the store
    assign new_valid = fetch_fire;
    assign new_seq   = next_seq;

    // write-back always advances, so a valid slot there is a one-cycle strobe
    assign wb_enter  = slot_valid[stage_writeback];
    assign wb_seq    = slot_seq[stage_writeback];
    assign wb_stalls = slot_stalls[stage_writeback];

    assign wb_seq_gap = wb_seq - last_wb_seq;

    //////////////////////////////
    // counters and valid bits
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count  <= '0;
            next_seq     <= '0;
            slot_valid   <= '0;
            squash_count <= '0;
            wb_seen      <= 1'b0;
        end else begin
            cycle_count <= cycle_count + cycle_t'(1);
            if (fetch_fire) begin
                next_seq <= next_seq + seq_t'(1);
            end
            if (wb_enter) begin
                wb_seen <= 1'b1;
            end

            // back end moves on every edge
            slot_valid[stage_writeback] <= slot_valid[stage_memory];
            slot_valid[stage_memory]    <= slot_valid[stage_execute];

            if (flush) begin
                // flush wins over stall
                slot_valid[stage_execute] <= 1'b0;
                slot_valid[stage_decode]  <= 1'b0;
                slot_valid[stage_fetch]   <= 1'b0;
                squash_count <= squash_count
                              + squash_cnt_t'(slot_valid[stage_fetch])
                              + squash_cnt_t'(slot_valid[stage_decode]);
            end else if (stall) begin
                // front end holds, bubble into execute
                slot_valid[stage_execute] <= 1'b0;
            end else begin
                slot_valid[stage_execute] <= slot_valid[stage_decode];
                slot_valid[stage_decode]  <= slot_valid[stage_fetch];
                slot_valid[stage_fetch]   <= fetch_fire;
            end
        end
    end

    //////////////////////////////
    // slot payload
    //////////////////////////////

    always_ff @(posedge clk) begin
        slot_seq[stage_writeback]    <= slot_seq[stage_memory];
        slot_stalls[stage_writeback] <= slot_stalls[stage_memory];
        slot_seq[stage_memory]       <= slot_seq[stage_execute];
        slot_stalls[stage_memory]    <= slot_stalls[stage_execute];

        if (wb_enter) begin
            last_wb_seq <= wb_seq;
        end

        if (!stall && !flush) begin
            slot_seq[stage_execute]    <= slot_seq[stage_decode];
            slot_stalls[stage_execute] <= slot_stalls[stage_decode];
            // stall count restarts as the tag enters decode
            slot_seq[stage_decode]     <= slot_seq[stage_fetch];
            slot_stalls[stage_decode]  <= '0;
            if (fetch_fire) begin
                slot_seq[stage_fetch] <= next_seq;
            end
        end else if (!flush && slot_valid[stage_decode]) begin
            // saturating decode stall count
            if (slot_stalls[stage_decode] != '1) begin
                slot_stalls[stage_decode] <= slot_stalls[stage_decode] + stall_cnt_t'(1);
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // the core holds off fetch while the front end stalls or flushes
    fetch_alone_a: assert property (
        @(posedge clk) disable iff (rst) fetch_fire |-> !(stall || flush)
    ) else $error("fetch accepted during stall or flush");

    // tags reach write-back in fetch order, squashed numbers skipped
    wb_order_a: assert property (
        @(posedge clk) disable iff (rst)
        (wb_enter && wb_seen) |-> (wb_seq_gap != '0 && !wb_seq_gap[$bits(seq_t)-1])
    ) else $error("write-back tag %0d out of order after %0d", wb_seq, last_wb_seq);

endmodule

/* source/trace_pkg.sv */
/*
 * trace-side definitions for the trace unit
 *   seq_t, cycle_t, stall_cnt_t, squash_cnt_t  widths of trace fields
 *   pipe_depth                                stage slot count
 *   store_aw, store_depth                     fetch record store sizing
 */

package trace_pkg;

    //////////////////////////////
    // trace field widths
    //////////////////////////////

    // per-fetch sequence number, wraps
    typedef logic [7:0] seq_t;

    // free running cycle count, cleared by reset, wraps
    typedef logic [15:0] cycle_t;

    // decode stall cycles of one instruction, saturates
    typedef logic [7:0] stall_cnt_t;

    // instructions removed from fetch and decode by flushes
    typedef logic [15:0] squash_cnt_t;

    //////////////////////////////
    // sizing
    //////////////////////////////

    // fetch, decode, execute, memory, write-back
    localparam int pipe_depth = 5;

    // record store is indexed by the low bits of seq_t
    // 16 entries against at most pipe_depth tags in flight
    localparam int store_aw = 4;
    localparam int store_depth = 1 << store_aw;

endpackage

/* source/pipe_pkg.sv */
/*
 * pipeline-side definitions for the trace unit
 *   instr_t  instruction word as fetched by the core
 *   stage_e  the five stages of the in-order pipeline
 */

package pipe_pkg;

    //////////////////////////////
    // instruction word
    //////////////////////////////

    // raw 32-bit word, no decode is done by the trace unit
    typedef logic [31:0] instr_t;

    //////////////////////////////
    // pipeline stages
    //////////////////////////////

    // listed in pipeline order
    // the value doubles as the slot index in the tag tracker
    typedef enum logic [2:0] {
        stage_fetch,
        stage_decode,
        stage_execute,
        stage_memory,
        stage_writeback
    } stage_e;

endpackage
